// ==== jogo_pkg.sv ====
package jogo_pkg;

    localparam int NUM_NOTAS       = 13;
    localparam int TAM_MUSICA      = 16;
    localparam int MAX_ERROS       = 3;
    localparam int DEBOUNCE_CICLOS = 4;
    localparam int TEMPO_NOTA      = 32;
    localparam int PAUSA_NOTA      = 8;

    // Buzzer half period is this plus twice the note index
    localparam int MEIO_PERIODO_BASE = 20;

    typedef logic [3:0]           nota_t;
    typedef logic [NUM_NOTAS-1:0] leds_t;
    typedef logic [3:0]           rodada_t;
    typedef logic [1:0]           erros_t;
    typedef logic [6:0]           seg7_t;

    typedef logic [$clog2(DEBOUNCE_CICLOS + 1)-1:0]               debounce_t;
    typedef logic [$clog2(TEMPO_NOTA)-1:0]                        tempo_t;
    typedef logic [$clog2(MEIO_PERIODO_BASE + 2 * NUM_NOTAS)-1:0] meio_periodo_t;

    // No note pressed or played
    localparam nota_t SEM_NOTA = 4'hF;

    typedef enum logic [3:0] {
        inicial        = 4'h0,
        toca_nota      = 4'h1,
        pausa          = 4'h2,
        espera_jogada  = 4'h3,
        compara        = 4'h4,
        proxima_rodada = 4'h5,
        fim_ganhou     = 4'h6,
        fim_perdeu     = 4'h7
    } estado_t;

    typedef struct packed {
        logic  valida;
        nota_t nota;
    } jogada_t;

    typedef struct packed {
        logic  ativo;
        nota_t nota;
    } toque_t;

endpackage

// ==== hexa7seg.sv ====
`timescale 1ns/100ps

module hexa7seg (
    input  logic [3:0]      hexa,
    output jogo_pkg::seg7_t display
);

    // Segments g..a, lit when high
    always_comb begin
        case (hexa)
            4'h0: display = 7'h3F;
            4'h1: display = 7'h06;
            4'h2: display = 7'h5B;
            4'h3: display = 7'h4F;
            4'h4: display = 7'h66;
            4'h5: display = 7'h6D;
            4'h6: display = 7'h7D;
            4'h7: display = 7'h07;
            4'h8: display = 7'h7F;
            4'h9: display = 7'h6F;
            4'hA: display = 7'h77;
            4'hB: display = 7'h7C;
            4'hC: display = 7'h39;
            4'hD: display = 7'h5E;
            4'hE: display = 7'h79;
            4'hF: display = 7'h71;
            default: display = 7'h00;
        endcase
    end

endmodule

// ==== memoria_musica.sv ====
`timescale 1ns/100ps

module memoria_musica (
    input  jogo_pkg::rodada_t endereco,
    output jogo_pkg::nota_t   nota_memoria
);

    // Melody, note index per address
    always_comb begin
        case (endereco)
            4'h0: nota_memoria = 4'd4;
            4'h1: nota_memoria = 4'd4;
            4'h2: nota_memoria = 4'd5;
            4'h3: nota_memoria = 4'd7;
            4'h4: nota_memoria = 4'd7;
            4'h5: nota_memoria = 4'd5;
            4'h6: nota_memoria = 4'd4;
            4'h7: nota_memoria = 4'd2;
            4'h8: nota_memoria = 4'd0;
            4'h9: nota_memoria = 4'd0;
            4'hA: nota_memoria = 4'd2;
            4'hB: nota_memoria = 4'd4;
            4'hC: nota_memoria = 4'd9;
            4'hD: nota_memoria = 4'd11;
            4'hE: nota_memoria = 4'd12;
            4'hF: nota_memoria = 4'd7;
            default: nota_memoria = 4'd0;
        endcase
    end

    always_comb begin
        assert (nota_memoria < jogo_pkg::nota_t'(jogo_pkg::NUM_NOTAS))
            else $error("nota_memoria out of range: %h", nota_memoria);
    end

endmodule

// ==== entrada_botoes.sv ====
`timescale 1ns/100ps

module entrada_botoes (
    input  logic              clock,
    input  logic              rst_n,
    input  jogo_pkg::leds_t   botoes,
    input  logic              iniciar,
    output jogo_pkg::jogada_t jogada,
    output logic              inicio
);

    // Start key rides on the top bit, above the note buttons
    logic [jogo_pkg::NUM_NOTAS:0] sinc1;
    logic [jogo_pkg::NUM_NOTAS:0] sinc2;
    jogo_pkg::debounce_t          cont_estavel;
    logic                         travado;
    logic                         mudou;
    logic                         estavel;
    logic                         um_quente;
    logic                         disparo;
    jogo_pkg::nota_t              indice;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sinc1 <= '0;
            sinc2 <= '0;
        end else begin
            sinc1 <= {iniciar, botoes};
            sinc2 <= sinc1;
        end
    end

    assign mudou   = (sinc1 != sinc2);
    assign estavel = (cont_estavel == jogo_pkg::debounce_t'(jogo_pkg::DEBOUNCE_CICLOS));

    // Stable count saturates, restarts on any change
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cont_estavel <= '0;
            travado      <= 1'b0;
        end else begin
            if (mudou) begin
                cont_estavel <= '0;
            end else if (!estavel) begin
                cont_estavel <= cont_estavel + 1'b1;
            end
            if (mudou) begin
                travado <= 1'b0;
            end else if (disparo) begin
                travado <= 1'b1;
            end
        end
    end

    assign um_quente = (sinc2 != '0) && ((sinc2 & (sinc2 - 1'b1)) == '0);
    assign disparo   = estavel && um_quente && !travado;

    // Lowest pressed button wins, only matters when one-hot
    always_comb begin
        indice = jogo_pkg::SEM_NOTA;
        for (int i = jogo_pkg::NUM_NOTAS - 1; i >= 0; i--) begin
            if (sinc2[i]) begin
                indice = jogo_pkg::nota_t'(i);
            end
        end
    end

    assign jogada.valida = disparo && !sinc2[jogo_pkg::NUM_NOTAS];
    assign jogada.nota   = indice;
    assign inicio        = disparo && sinc2[jogo_pkg::NUM_NOTAS];

    a_jogada_unica: assert property (@(posedge clock) disable iff (!rst_n)
        jogada.valida |=> !jogada.valida)
        else $error("jogada.valida high on two consecutive cycles");

endmodule

// ==== unidade_controle.sv ====
`timescale 1ns/100ps

module unidade_controle (
    input  logic              clock,
    input  logic              rst_n,
    input  jogo_pkg::jogada_t jogada,
    input  logic              inicio,
    input  jogo_pkg::nota_t   nota_memoria,
    output jogo_pkg::rodada_t endereco,
    output jogo_pkg::toque_t  toque,
    output jogo_pkg::rodada_t rodada,
    output jogo_pkg::estado_t estado,
    output logic              vez_jogador,
    output logic              errou_nota,
    output logic              ganhou,
    output logic              perdeu
);

    jogo_pkg::tempo_t cont_tempo;
    jogo_pkg::erros_t erros;
    jogo_pkg::nota_t  nota_jogada;
    logic             fim_toque;
    logic             fim_pausa;
    logic             fim_rodada;
    logic             ultima_rodada;
    logic             ultimo_erro;
    logic             acertou;

    assign fim_toque     = (cont_tempo == jogo_pkg::tempo_t'(jogo_pkg::TEMPO_NOTA - 1));
    assign fim_pausa     = (cont_tempo == jogo_pkg::tempo_t'(jogo_pkg::PAUSA_NOTA - 1));
    assign fim_rodada    = (endereco == rodada);
    assign ultima_rodada = (rodada == jogo_pkg::rodada_t'(jogo_pkg::TAM_MUSICA - 1));
    assign ultimo_erro   = (erros == jogo_pkg::erros_t'(jogo_pkg::MAX_ERROS - 1));
    assign acertou       = (nota_jogada == nota_memoria);

    // Rodada holds round number minus one
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            estado     <= jogo_pkg::inicial;
            cont_tempo <= '0;
            endereco   <= '0;
            rodada     <= '0;
            erros      <= '0;
            errou_nota <= 1'b0;
        end else begin
            errou_nota <= 1'b0;
            case (estado)
                jogo_pkg::inicial, jogo_pkg::fim_ganhou, jogo_pkg::fim_perdeu: begin
                    if (inicio) begin
                        cont_tempo <= '0;
                        endereco   <= '0;
                        rodada     <= '0;
                        erros      <= '0;
                        estado     <= jogo_pkg::toca_nota;
                    end
                end
                jogo_pkg::toca_nota: begin
                    if (fim_toque) begin
                        cont_tempo <= '0;
                        estado     <= jogo_pkg::pausa;
                    end else begin
                        cont_tempo <= cont_tempo + 1'b1;
                    end
                end
                jogo_pkg::pausa: begin
                    if (fim_pausa) begin
                        cont_tempo <= '0;
                        if (fim_rodada) begin
                            endereco <= '0;
                            estado   <= jogo_pkg::espera_jogada;
                        end else begin
                            endereco <= endereco + 1'b1;
                            estado   <= jogo_pkg::toca_nota;
                        end
                    end else begin
                        cont_tempo <= cont_tempo + 1'b1;
                    end
                end
                jogo_pkg::espera_jogada: begin
                    if (jogada.valida) begin
                        estado <= jogo_pkg::compara;
                    end
                end
                jogo_pkg::compara: begin
                    if (acertou) begin
                        if (!fim_rodada) begin
                            endereco <= endereco + 1'b1;
                            estado   <= jogo_pkg::espera_jogada;
                        end else if (ultima_rodada) begin
                            estado <= jogo_pkg::fim_ganhou;
                        end else begin
                            estado <= jogo_pkg::proxima_rodada;
                        end
                    end else begin
                        errou_nota <= 1'b1;
                        erros      <= erros + 1'b1;
                        if (ultimo_erro) begin
                            estado <= jogo_pkg::fim_perdeu;
                        end else begin
                            // Replay the same round
                            cont_tempo <= '0;
                            endereco   <= '0;
                            estado     <= jogo_pkg::toca_nota;
                        end
                    end
                end
                jogo_pkg::proxima_rodada: begin
                    rodada     <= rodada + 1'b1;
                    endereco   <= '0;
                    cont_tempo <= '0;
                    estado     <= jogo_pkg::toca_nota;
                end
                default: begin
                    estado <= jogo_pkg::inicial;
                end
            endcase
        end
    end

    // Pressed note kept for the compare cycle
    always_ff @(posedge clock) begin
        if (estado == jogo_pkg::espera_jogada && jogada.valida) begin
            nota_jogada <= jogada.nota;
        end
    end

    always_comb begin
        toque.ativo = (estado == jogo_pkg::toca_nota);
        toque.nota  = toque.ativo ? nota_memoria : jogo_pkg::SEM_NOTA;
    end

    assign vez_jogador = (estado == jogo_pkg::espera_jogada);
    assign ganhou      = (estado == jogo_pkg::fim_ganhou);
    assign perdeu      = (estado == jogo_pkg::fim_perdeu);

    a_fim_exclusivo: assert property (@(posedge clock) disable iff (!rst_n)
        !(ganhou && perdeu))
        else $error("ganhou and perdeu both high");

    a_erro_apos_compara: assert property (@(posedge clock) disable iff (!rst_n)
        errou_nota |-> $past(estado) == jogo_pkg::compara)
        else $error("errou_nota raised outside compare");

endmodule

// ==== saida_som.sv ====
`timescale 1ns/100ps

module saida_som (
    input  logic              clock,
    input  logic              rst_n,
    input  jogo_pkg::toque_t  toque,
    input  jogo_pkg::rodada_t rodada,
    input  jogo_pkg::estado_t estado,
    output jogo_pkg::leds_t   leds,
    output logic              pulso_buzzer,
    output jogo_pkg::seg7_t   db_estado,
    output jogo_pkg::seg7_t   db_nota,
    output jogo_pkg::seg7_t   db_rodada
);

    jogo_pkg::meio_periodo_t cont_buzzer;
    jogo_pkg::meio_periodo_t recarga;
    jogo_pkg::rodada_t       rodada_exibida;
    jogo_pkg::seg7_t         seg_estado;
    jogo_pkg::seg7_t         seg_nota;
    jogo_pkg::seg7_t         seg_rodada;

    // Count down from half period minus one
    assign recarga = jogo_pkg::meio_periodo_t'(jogo_pkg::MEIO_PERIODO_BASE
                                               + 2 * toque.nota - 1);
    assign rodada_exibida = rodada + 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            leds         <= '0;
            pulso_buzzer <= 1'b0;
            cont_buzzer  <= '0;
            db_estado    <= '0;
            db_nota      <= '0;
            db_rodada    <= '0;
        end else begin
            if (toque.ativo) begin
                leds <= jogo_pkg::leds_t'(1) << toque.nota;
                if (cont_buzzer == '0) begin
                    pulso_buzzer <= ~pulso_buzzer;
                    cont_buzzer  <= recarga;
                end else begin
                    cont_buzzer <= cont_buzzer - 1'b1;
                end
            end else begin
                leds         <= '0;
                pulso_buzzer <= 1'b0;
                cont_buzzer  <= '0;
            end
            db_estado <= seg_estado;
            db_nota   <= toque.ativo ? seg_nota : '0;
            db_rodada <= seg_rodada;
        end
    end

    hexa7seg display_estado (.hexa(4'(estado)),   .display(seg_estado));
    hexa7seg display_nota   (.hexa(toque.nota),   .display(seg_nota));
    hexa7seg display_rodada (.hexa(rodada_exibida), .display(seg_rodada));

    a_leds_um_quente: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(leds))
        else $error("leds not one-hot: %h", leds);

endmodule

// ==== circuito_principal.sv ====
`timescale 1ns/100ps

module circuito_principal (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            iniciar,
    input  jogo_pkg::leds_t botoes,

    output logic            ganhou,
    output logic            perdeu,
    output logic            vez_jogador,
    output logic            errou_nota,
    output jogo_pkg::leds_t leds,
    output logic            pulso_buzzer,

    output jogo_pkg::seg7_t db_estado,
    output jogo_pkg::seg7_t db_nota,
    output jogo_pkg::seg7_t db_rodada
);

    jogo_pkg::jogada_t jogada;
    logic              inicio;
    jogo_pkg::rodada_t endereco;
    jogo_pkg::nota_t   nota_memoria;
    jogo_pkg::toque_t  toque;
    jogo_pkg::rodada_t rodada;
    jogo_pkg::estado_t estado;

    // Buttons and start key
    entrada_botoes entrada_botoes (
        .clock   ( clock   ),
        .rst_n   ( rst_n   ),
        .botoes  ( botoes  ),
        .iniciar ( iniciar ),
        .jogada  ( jogada  ),
        .inicio  ( inicio  )
    );

    unidade_controle unidade_controle (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .jogada       ( jogada       ),
        .inicio       ( inicio       ),
        .nota_memoria ( nota_memoria ),
        .endereco     ( endereco     ),
        .toque        ( toque        ),
        .rodada       ( rodada       ),
        .estado       ( estado       ),
        .vez_jogador  ( vez_jogador  ),
        .errou_nota   ( errou_nota   ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       )
    );

    memoria_musica memoria_musica (
        .endereco     ( endereco     ),
        .nota_memoria ( nota_memoria )
    );

    // LEDs, buzzer and debug digits
    saida_som saida_som (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .toque        ( toque        ),
        .rodada       ( rodada       ),
        .estado       ( estado       ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .db_estado    ( db_estado    ),
        .db_nota      ( db_nota      ),
        .db_rodada    ( db_rodada    )
    );

endmodule

// ==== tb_circuito_principal.sv ====
`timescale 1ns/100ps

module tb_circuito_principal;

    localparam int PERIODO       = 4;
    localparam int CICLOS_RESET  = 10;
    localparam int DURACAO_MIN   = jogo_pkg::DEBOUNCE_CICLOS + 3;
    localparam int NOTAS_TOCADAS = 136;
    localparam int PRESSOES      = 200;
    localparam int CICLOS_NOTA   = jogo_pkg::TEMPO_NOTA + jogo_pkg::PAUSA_NOTA;
    // One and a half times the longest expected run
    localparam int LIMITE_NS = 3 * (NOTAS_TOCADAS * CICLOS_NOTA + PRESSOES * 20) * PERIODO / 2;

    logic            clock;
    logic            rst_n;
    logic            iniciar;
    jogo_pkg::leds_t botoes;
    logic            ganhou;
    logic            perdeu;
    logic            vez_jogador;
    logic            errou_nota;
    jogo_pkg::leds_t leds;
    logic            pulso_buzzer;
    jogo_pkg::seg7_t db_estado;
    jogo_pkg::seg7_t db_nota;
    jogo_pkg::seg7_t db_rodada;

    int              tocadas[$];
    int              anterior[$];
    jogo_pkg::leds_t leds_ant;
    logic            pulso_ant;
    logic            limpar_na_proxima;
    int              ciclos_buzzer;
    int              estado_ant;
    int              pulsos_erro;
    int              notas_erradas;
    int              rodadas;
    int              erros;

    circuito_principal DUT (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .iniciar      ( iniciar      ),
        .botoes       ( botoes       ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .vez_jogador  ( vez_jogador  ),
        .errou_nota   ( errou_nota   ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .db_estado    ( db_estado    ),
        .db_nota      ( db_nota      ),
        .db_rodada    ( db_rodada    )
    );

    always #(PERIODO / 2) clock = ~clock;

    task erro_valor(input string nome, input logic [31:0] obtido, input logic [31:0] esperado);
        $display("Error %s: got %h, expected %h", nome, obtido, esperado);
        erros++;
    endtask

    task erro_texto(input string mensagem);
        $display("%s", mensagem);
        erros++;
    endtask

    task imprime_resumo();
        $display("Summary: %0d rounds played, %0d wrong notes, %0d errors",
                 rodadas, notas_erradas, erros);
    endtask

    function automatic int indice_led(input jogo_pkg::leds_t valor);
        int indice;
        indice = -1;
        for (int i = 0; i < jogo_pkg::NUM_NOTAS; i++) begin
            if (valor[i]) begin
                indice = i;
            end
        end
        return indice;
    endfunction

    // Standard hex digit glyphs, segment a in bit 0
    function automatic jogo_pkg::seg7_t codigo_7seg(input int digito);
        case (digito)
            0:  return 7'h3F;
            1:  return 7'h06;
            2:  return 7'h5B;
            3:  return 7'h4F;
            4:  return 7'h66;
            5:  return 7'h6D;
            6:  return 7'h7D;
            7:  return 7'h07;
            8:  return 7'h7F;
            9:  return 7'h6F;
            10: return 7'h77;
            11: return 7'h7C;
            12: return 7'h39;
            13: return 7'h5E;
            14: return 7'h79;
            15: return 7'h71;
            default: return 7'h00;
        endcase
    endfunction

    function automatic int nota_errada(input int certa);
        int nota;
        nota = int'($urandom % jogo_pkg::NUM_NOTAS);
        while (nota == certa) begin
            nota = int'($urandom % jogo_pkg::NUM_NOTAS);
        end
        return nota;
    endfunction

    a_leds_um_quente: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(leds))
        else erro_texto("leds has more than one note lit");
    a_buzzer_mudo: assert property (@(posedge clock) disable iff (!rst_n)
        leds == '0 |-> !pulso_buzzer)
        else erro_texto("pulso_buzzer high while no note is lit");
    a_erro_um_ciclo: assert property (@(posedge clock) disable iff (!rst_n)
        errou_nota |=> !errou_nota)
        else erro_texto("errou_nota held for more than one cycle");
    a_fim_parado: assert property (@(posedge clock) disable iff (!rst_n)
        (ganhou || perdeu) |-> (!vez_jogador && leds == '0))
        else erro_texto("game over but the player's turn or a note is still active");

    // Records each playback and times the buzzer against the lit note
    always @(negedge clock) begin
        if (!rst_n) begin
            leds_ant          = '0;
            pulso_ant         = 1'b0;
            limpar_na_proxima = 1'b0;
            ciclos_buzzer     = 0;
            estado_ant        = -1;
        end else begin
            if (vez_jogador) begin
                limpar_na_proxima = 1'b1;
            end
            if (errou_nota) begin
                pulsos_erro++;
            end
            // Debug digits trail the state by one cycle
            if (estado_ant >= 0) begin
                assert (db_estado == codigo_7seg(estado_ant))
                    else erro_valor("db_estado", 32'(db_estado),
                                    32'(codigo_7seg(estado_ant)));
            end
            if (leds == '0) begin
                assert (db_nota == 7'h00) else erro_valor("db_nota", 32'(db_nota), 0);
            end else begin
                assert (db_nota == codigo_7seg(indice_led(leds)))
                    else erro_valor("db_nota", 32'(db_nota),
                                    32'(codigo_7seg(indice_led(leds))));
                assert (db_estado == codigo_7seg(int'(jogo_pkg::toca_nota)))
                    else erro_valor("db_estado", 32'(db_estado),
                                    32'(codigo_7seg(int'(jogo_pkg::toca_nota))));
            end
            if (leds != '0 && leds != leds_ant) begin
                if (limpar_na_proxima) begin
                    tocadas.delete();
                    limpar_na_proxima = 1'b0;
                end
                tocadas.push_back(indice_led(leds));
                ciclos_buzzer = 0;
            end else if (leds != '0) begin
                ciclos_buzzer++;
                if (pulso_buzzer != pulso_ant) begin
                    assert (ciclos_buzzer == jogo_pkg::MEIO_PERIODO_BASE + 2 * indice_led(leds))
                        else erro_valor("pulso_buzzer half period", ciclos_buzzer,
                                        jogo_pkg::MEIO_PERIODO_BASE + 2 * indice_led(leds));
                    ciclos_buzzer = 0;
                end else begin
                    assert (ciclos_buzzer < jogo_pkg::MEIO_PERIODO_BASE + 2 * indice_led(leds))
                        else erro_texto("pulso_buzzer missed a toggle");
                end
            end
            leds_ant  = leds;
            pulso_ant = pulso_buzzer;
            if (vez_jogador) begin
                estado_ant = int'(jogo_pkg::espera_jogada);
            end else if (ganhou) begin
                estado_ant = int'(jogo_pkg::fim_ganhou);
            end else if (perdeu) begin
                estado_ant = int'(jogo_pkg::fim_perdeu);
            end else begin
                estado_ant = -1;
            end
        end
    end

    // Negative note means the start key
    task automatic pressiona(input int nota);
        int duracao;
        duracao = DURACAO_MIN + int'($urandom % 6);
        @(posedge clock);
        if (nota < 0) begin
            iniciar <= 1'b1;
        end else begin
            botoes <= jogo_pkg::leds_t'(1) << nota;
        end
        repeat (duracao) @(posedge clock);
        iniciar <= 1'b0;
        botoes  <= '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
    endtask

    task automatic toca_durante_reproducao();
        int antes;
        while (leds == '0) @(negedge clock);
        antes = pulsos_erro;
        pressiona(int'($urandom % jogo_pkg::NUM_NOTAS));
        assert (pulsos_erro == antes)
            else erro_valor("errou_nota pulses", pulsos_erro - antes, 0);
        assert (!vez_jogador) else erro_texto("playback ended early after a press");
    endtask

    // Repeats round r, with a wrong note at pos_erro when it is not negative
    task automatic joga_rodada(input int r, input int pos_erro, input bit perturbar);
        int seq[$];
        int antes;
        int comum;
        if (perturbar) begin
            toca_durante_reproducao();
        end
        while (!vez_jogador) @(negedge clock);
        seq = tocadas;
        rodadas++;
        assert (seq.size() == r) else erro_valor("playback length", seq.size(), r);
        comum = (anterior.size() < r) ? anterior.size() : r;
        for (int i = 0; i < comum && i < seq.size(); i++) begin
            assert (seq[i] == anterior[i]) else erro_valor("leds note", seq[i], anterior[i]);
        end
        anterior = seq;
        for (int i = 0; i < seq.size(); i++) begin
            assert (vez_jogador) else erro_texto("vez_jogador low before a press");
            antes = pulsos_erro;
            if (i == pos_erro) begin
                pressiona(nota_errada(seq[i]));
                notas_erradas++;
                assert (pulsos_erro == antes + 1)
                    else erro_valor("errou_nota pulses", pulsos_erro - antes, 1);
                return;
            end
            pressiona(seq[i]);
            assert (pulsos_erro == antes)
                else erro_valor("errou_nota pulses", pulsos_erro - antes, 0);
        end
    endtask

    initial begin
        void'($urandom(75376));
        clock         = 1'b0;
        rst_n         = 1'b0;
        iniciar       = 1'b0;
        botoes        = '0;
        pulsos_erro   = 0;
        notas_erradas = 0;
        rodadas       = 0;
        erros         = 0;
        repeat (CICLOS_RESET) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        assert (!vez_jogador && !errou_nota && !ganhou && !perdeu)
            else erro_texto("status outputs not low after reset");
        assert (leds == '0) else erro_valor("leds", 32'(leds), 0);
        assert (!pulso_buzzer) else erro_valor("pulso_buzzer", 32'(pulso_buzzer), 0);

        // First game is won, with one wrong note on the way
        pressiona(-1);
        for (int r = 1; r <= jogo_pkg::TAM_MUSICA; r++) begin
            if (r == 4) begin
                joga_rodada(r, 2, 1'b0);
            end
            joga_rodada(r, -1, (r % 5) == 3);
        end
        assert (ganhou) else erro_valor("ganhou", 32'(ganhou), 1);
        assert (db_rodada == 7'h3F) else erro_valor("db_rodada", 32'(db_rodada), 32'h3F);
        repeat (30) begin
            @(negedge clock);
            assert (ganhou && !perdeu) else erro_texto("ganhou dropped before iniciar");
        end

        // Second game is lost on round 2
        pressiona(-1);
        assert (!ganhou) else erro_valor("ganhou", 32'(ganhou), 0);
        joga_rodada(1, -1, 1'b0);
        joga_rodada(2, 1, 1'b0);
        joga_rodada(2, 0, 1'b1);
        joga_rodada(2, 1, 1'b0);
        repeat (20) begin
            @(negedge clock);
            assert (perdeu && !ganhou) else erro_texto("perdeu not held after the third error");
        end

        imprime_resumo();
        if (erros == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(LIMITE_NS);
        $display("Timeout: the game did not finish within %0d ns", LIMITE_NS);
        imprime_resumo();
        $display("Test failed");
        $finish;
    end

endmodule

// ==== circuito_principal.f ====
jogo_pkg.sv
hexa7seg.sv
memoria_musica.sv
entrada_botoes.sv
unidade_controle.sv
saida_som.sv
circuito_principal.sv
tb_circuito_principal.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_circuito_principal
RTL_TOP  ?= circuito_principal
LOG      ?= sim.log
FILELIST ?= circuito_principal.f
BUILD    ?= obj_dir
VFLAGS   ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(SIM) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
